// ==== Bender.yml ====
package:
  name: pm_ctrl

export_include_dirs:
  - hw

sources:
  - hw/pm_uop_pkg.sv
  - hw/pm_cmd_if.sv
  - hw/pm_program_rom.sv
  - hw/pm_scalar_regs.sv
  - hw/pm_ctrl.sv
  - hw/pm_ctrl_top.sv
  - target: simulation
    files:
      - sim/tb_pm_ctrl.sv

// ==== compile.f ====
+incdir+hw
hw/pm_uop_pkg.sv
hw/pm_cmd_if.sv
hw/pm_program_rom.sv
hw/pm_scalar_regs.sv
hw/pm_ctrl.sv
hw/pm_ctrl_top.sv
sim/tb_pm_ctrl.sv

// ==== hw/pm_cmd_if.sv ====
interface pm_cmd_if;
    import pm_uop_pkg::*;

    pm_cmd_t cmd;        // Pending command, level until busy
    logic    sca_en;     // Side-channel protection for this command
    logic    digit;      // Current scalar digit, MSB of the window
    logic    req_digit;  // One-cycle pulse, shift to next digit
    logic    busy;

    modport regs (
        output cmd, sca_en, digit,
        input  req_digit, busy
    );

    modport ctrl (
        input  cmd, sca_en, digit,
        output req_digit, busy
    );

endinterface

// ==== hw/pm_ctrl.sv ====
`include "pm_defs.svh"

module pm_ctrl (
    input  logic                      clk,
    input  logic                      reset_n,
    pm_cmd_if.ctrl                    cmd_if,
    output pm_uop_pkg::pm_prog_addr_t prog_addr_o,
    input  pm_uop_pkg::pm_instr_t     prog_instr_i,
    output pm_uop_pkg::pm_instr_t     instr_o
);
    import pm_uop_pkg::*;

    localparam int WIN_W  = `PM_SCALAR_W + `PM_RND_W;
    localparam int LCNT_W = $clog2(WIN_W + 1);
    localparam int SCNT_W = $clog2(`PM_MULT_DELAY + 1);

    pm_prog_addr_t     prog_cntr;
    pm_cmd_t           cmd_reg;      // Command being run
    logic [LCNT_W-1:0] mont_cntr;    // Ladder steps left
    logic [SCNT_W-1:0] stall_cntr;
    logic              stalled;
    pm_instr_t         pipe1;
    pm_instr_t         pipe2;
    logic              lad1, lad2;   // Word belongs to a ladder step
    logic              shf1, shf2;   // Last word of a non-final step
    logic              stall_flag;
    logic              is_mult;
    logic              freeze;
    logic              in_ladder;

    // Constant-time swap of bank-1 addresses
    function automatic pm_opr_addr_t swap_addr(input pm_opr_addr_t a, input logic lad,
                                               input logic digit);
        if (lad && (a[`PM_OPR_ADDR_W-1:3] == LADDER_BANK)) begin
            return {a[`PM_OPR_ADDR_W-1:3], a[2] ^ digit, a[1:0]};
        end
        return a;
    endfunction

    // ------------------------------------------------------------------
    // Stall on arithmetic words at the issue stage
    // ------------------------------------------------------------------
    assign stall_flag = pipe2.opcode[OP_ADD_EN_BIT] | pipe2.opcode[OP_MUL_EN_BIT];
    assign is_mult    = pipe2.opcode[OP_MUL_EN_BIT];
    assign freeze     = (!stalled && stall_flag) || (stalled && (stall_cntr != '0));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            stalled    <= 1'b0;
            stall_cntr <= '0;
        end else if (!stalled && stall_flag) begin
            stalled    <= 1'b1;
            stall_cntr <= is_mult ? SCNT_W'(`PM_MULT_DELAY) : SCNT_W'(`PM_ADD_DELAY);
        end else if (stalled && (stall_cntr != '0)) begin
            stall_cntr <= stall_cntr - 1'b1;
        end else begin
            stalled    <= 1'b0;          // Word moves on with this release
        end
    end

    // ------------------------------------------------------------------
    // Sequencing FSM over routine boundaries
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prog_cntr <= NOP_A;
            cmd_reg   <= IDLE;
            mont_cntr <= '0;
        end else if (prog_cntr == NOP_A) begin
            // Launch may overlap a stalled drain since NOP_A is never fetched
            cmd_reg <= cmd_if.cmd;
            case (cmd_if.cmd)
                KEYGEN, SIGN: begin
                    mont_cntr <= cmd_if.sca_en ? LCNT_W'(WIN_W) : LCNT_W'(`PM_SCALAR_W);
                    prog_cntr <= PM_INIT_G_S;
                end
                VER0:    prog_cntr <= VER0_P0_S;
                VER1: begin
                    mont_cntr <= LCNT_W'(`PM_SCALAR_W);
                    prog_cntr <= PM_INIT_G_S;
                end
                VER2:    prog_cntr <= VER1_ST_S;
                default: prog_cntr <= NOP_A;
            endcase
        end else if (!freeze) begin
            case (prog_cntr)
                VER1_ST_E: begin
                    mont_cntr <= LCNT_W'(`PM_SCALAR_W);
                    prog_cntr <= PM_INIT_PK_S;
                end
                PM_INIT_G_E, PM_INIT_PK_E: prog_cntr <= PM_INIT_S;
                PM_INIT_E: begin                       // First ladder step
                    mont_cntr <= mont_cntr - 1'b1;
                    prog_cntr <= PA_S;
                end
                PA_E:      prog_cntr <= PD_S;
                PD_E: begin
                    if (mont_cntr == '0) begin         // Ladder done
                        case (cmd_reg)
                            VER1:    prog_cntr <= NOP_A;
                            VER2:    prog_cntr <= VER2_PA_S;
                            default: prog_cntr <= INV_S;
                        endcase
                    end else begin
                        mont_cntr <= mont_cntr - 1'b1;
                        prog_cntr <= PA_S;
                    end
                end
                VER2_PA_E: prog_cntr <= INV_S;
                INV_E:     prog_cntr <= CONV_S;
                CONV_E:    prog_cntr <= (cmd_reg == SIGN) ? SIGN0_S : NOP_A;
                SIGN0_E:   prog_cntr <= INVQ_S;
                INVQ_E: begin
                    case (cmd_reg)
                        SIGN:    prog_cntr <= SIGN1_S;
                        VER0:    prog_cntr <= VER0_P1_S;
                        default: prog_cntr <= NOP_A;
                    endcase
                end
                VER0_P0_E:            prog_cntr <= INVQ_S;
                SIGN1_E, VER0_P1_E:   prog_cntr <= NOP_A;
                default:              prog_cntr <= prog_cntr + 1'b1;
            endcase
        end
    end

    assign prog_addr_o = prog_cntr;
    assign in_ladder   = (prog_cntr >= PA_S) && (prog_cntr <= PD_E);

    // ------------------------------------------------------------------
    // Two-stage pipeline with tags travelling alongside their words
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pipe1 <= '{NOP, '0, '0};
            pipe2 <= '{NOP, '0, '0};
            lad1  <= 1'b0;
            lad2  <= 1'b0;
            shf1  <= 1'b0;
            shf2  <= 1'b0;
        end else if (!freeze) begin
            pipe1 <= prog_instr_i;
            pipe2 <= pipe1;
            lad1  <= in_ladder;
            lad2  <= lad1;
            shf1  <= (prog_cntr == PD_E) && (mont_cntr != '0);
            shf2  <= shf1;
        end
    end

    // Window shifts as the next step's first word enters pipe2
    assign cmd_if.req_digit = shf2 && !freeze;
    assign cmd_if.busy      = (prog_cntr != NOP_A) || (cmd_if.cmd != IDLE);

    // Output stage repeats pipe2 while frozen
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            instr_o <= '{NOP, '0, '0};
        end else begin
            instr_o.opcode   <= pipe2.opcode;
            instr_o.opa_addr <= swap_addr(pipe2.opa_addr, lad2, cmd_if.digit);
            instr_o.opb_addr <= swap_addr(pipe2.opb_addr, lad2, cmd_if.digit);
        end
    end

    // Stall counter stays within the multiply delay and never wraps
    assert property (@(posedge clk) disable iff (!reset_n)
        stall_cntr <= SCNT_W'(`PM_MULT_DELAY));

    // Busy only falls once every ladder step has been issued
    assert property (@(posedge clk) disable iff (!reset_n)
        $fell(cmd_if.busy) |-> (mont_cntr == '0));

endmodule

// ==== hw/pm_ctrl_top.sv ====
`include "pm_defs.svh"

module pm_ctrl_top (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      start_i,
    input  logic [2:0]                cmd_i,
    input  logic                      sca_en_i,
    input  logic                      scalar_wr_i,
    input  logic [`PM_SCALAR_W-1:0]   scalar_i,
    input  logic [`PM_RND_W-1:0]      rnd_i,
    output logic                      busy_o,
    output logic [3:0]                opcode_o,
    output logic [`PM_OPR_ADDR_W-1:0] opa_addr_o,
    output logic [`PM_OPR_ADDR_W-1:0] opb_addr_o
);
    import pm_uop_pkg::*;

    pm_prog_addr_t prog_addr;
    pm_instr_t     prog_instr;   // ROM word at prog_addr
    pm_instr_t     instr;        // Output stage

    pm_cmd_if cmd_if ();

    pm_scalar_regs i_pm_scalar_regs (
        .clk         (clk),
        .reset_n     (reset_n),
        .start_i     (start_i),
        .cmd_i       (pm_cmd_t'(cmd_i)),
        .sca_en_i    (sca_en_i),
        .scalar_wr_i (scalar_wr_i),
        .scalar_i    (scalar_i),
        .rnd_i       (rnd_i),
        .cmd_if      (cmd_if.regs)
    );

    pm_ctrl i_pm_ctrl (
        .clk          (clk),
        .reset_n      (reset_n),
        .cmd_if       (cmd_if.ctrl),
        .prog_addr_o  (prog_addr),
        .prog_instr_i (prog_instr),
        .instr_o      (instr)
    );

    pm_program_rom i_pm_program_rom (
        .clk     (clk),
        .reset_n (reset_n),
        .addr_i  (prog_addr),
        .instr_o (prog_instr)
    );

    assign busy_o     = cmd_if.busy;
    assign opcode_o   = instr.opcode;
    assign opa_addr_o = instr.opa_addr;
    assign opb_addr_o = instr.opb_addr;

endmodule

// ==== hw/pm_defs.svh ====
`ifndef PM_DEFS_SVH
`define PM_DEFS_SVH

// ----------------------------------------------------------------------
// Datapath widths
// ----------------------------------------------------------------------
`define PM_SCALAR_W     16  // Secret scalar
`define PM_RND_W        8   // Random extension above the scalar
`define PM_PROG_ADDR_W  7   // Microcode ROM depth 128
`define PM_OPR_ADDR_W   6   // Bank[5:3], swap[2], reg[1:0]

// ----------------------------------------------------------------------
// Arithmetic latencies, counted as extra stall cycles minus one
// ----------------------------------------------------------------------
`define PM_MULT_DELAY   6
`define PM_ADD_DELAY    1

// Bank-1 micro-ops in one ladder step (PA plus PD)
`define PM_LADDER_UOPS  8

`endif

// ==== hw/pm_program_rom.sv ====
`include "pm_defs.svh"

module pm_program_rom (
    input  logic                      clk,
    input  logic                      reset_n,
    input  pm_uop_pkg::pm_prog_addr_t addr_i,
    output pm_uop_pkg::pm_instr_t     instr_o
);
    import pm_uop_pkg::*;

    // Operand addresses in octal: high digit bank, low digit {swap, reg}
    // Bank 0 inputs, 1 ladder R0/R1, 2 work, 3 affine, 4-6 mod q and stores
    always_comb begin
        case (addr_i)
            // Load base point G
            PM_INIT_G_S      : instr_o = '{STORE, 6'o20, 6'o00};
            PM_INIT_G_S + 1  : instr_o = '{STORE, 6'o21, 6'o01};
            PM_INIT_G_E      : instr_o = '{MUL_P, 6'o22, 6'o02};
            // Load public key PK
            PM_INIT_PK_S     : instr_o = '{STORE, 6'o20, 6'o04};
            PM_INIT_PK_S + 1 : instr_o = '{STORE, 6'o21, 6'o05};
            PM_INIT_PK_E     : instr_o = '{MUL_P, 6'o22, 6'o06};
            // R1 = PD(R0)
            PM_INIT_S        : instr_o = '{MUL_P, 6'o23, 6'o20};
            PM_INIT_S + 1    : instr_o = '{ADD_P, 6'o24, 6'o21};
            PM_INIT_S + 2    : instr_o = '{MUL_P, 6'o25, 6'o22};
            PM_INIT_E        : instr_o = '{SUB_P, 6'o26, 6'o23};

            // ----------------------------------------------------------
            // Ladder step, the only code with opa in bank 1 (swap bit 0)
            // ----------------------------------------------------------
            PA_S             : instr_o = '{MUL_P, 6'o10, 6'o11};
            PA_S + 1         : instr_o = '{ADD_P, 6'o12, 6'o13};
            PA_S + 2         : instr_o = '{MUL_P, 6'o11, 6'o20};
            PA_E             : instr_o = '{SUB_P, 6'o13, 6'o21};
            PD_S             : instr_o = '{MUL_P, 6'o10, 6'o10};
            PD_S + 1         : instr_o = '{ADD_P, 6'o12, 6'o22};
            PD_S + 2         : instr_o = '{MUL_P, 6'o13, 6'o23};
            PD_E             : instr_o = '{SUB_P, 6'o11, 6'o20};

            // FLT inversion mod p, shortened exponent chain
            INV_S            : instr_o = '{MUL_P, 6'o30, 6'o22};
            INV_S + 1        : instr_o = '{MUL_P, 6'o31, 6'o30};
            INV_S + 2        : instr_o = '{MUL_P, 6'o32, 6'o31};
            INV_E            : instr_o = '{ADD_P, 6'o33, 6'o32};
            // Projective Montgomery to affine normal
            CONV_S           : instr_o = '{MUL_P, 6'o34, 6'o20};
            CONV_S + 1       : instr_o = '{MUL_P, 6'o35, 6'o21};
            CONV_S + 2       : instr_o = '{STORE, 6'o36, 6'o34};
            CONV_E           : instr_o = '{STORE, 6'o37, 6'o35};
            // h + r*privkey
            SIGN0_S          : instr_o = '{MUL_Q, 6'o40, 6'o03};
            SIGN0_S + 1      : instr_o = '{ADD_Q, 6'o41, 6'o40};
            SIGN0_E          : instr_o = '{STORE, 6'o42, 6'o41};
            INVQ_S           : instr_o = '{MUL_Q, 6'o43, 6'o42};  // Inversion mod q
            INVQ_S + 1       : instr_o = '{MUL_Q, 6'o44, 6'o43};
            INVQ_E           : instr_o = '{SUB_Q, 6'o45, 6'o44};
            SIGN1_S          : instr_o = '{MUL_Q, 6'o46, 6'o45};  // s = k_inv * (h + r*d)
            SIGN1_S + 1      : instr_o = '{ADD_Q, 6'o47, 6'o46};
            SIGN1_E          : instr_o = '{STORE, 6'o50, 6'o47};
            VER0_P0_S        : instr_o = '{MUL_Q, 6'o40, 6'o06};  // Inputs to Montgomery form
            VER0_P0_S + 1    : instr_o = '{MUL_Q, 6'o41, 6'o07};
            VER0_P0_E        : instr_o = '{STORE, 6'o42, 6'o41};
            VER0_P1_S        : instr_o = '{MUL_Q, 6'o51, 6'o40};  // h*s_inv, r*s_inv
            VER0_P1_S + 1    : instr_o = '{MUL_Q, 6'o52, 6'o45};
            VER0_P1_E        : instr_o = '{STORE, 6'o53, 6'o52};
            VER1_ST_S        : instr_o = '{STORE, 6'o60, 6'o20};  // Keep VER1 ladder result
            VER1_ST_E        : instr_o = '{STORE, 6'o61, 6'o21};
            VER2_PA_S        : instr_o = '{ADD_P, 6'o62, 6'o60};  // Combine both products
            VER2_PA_S + 1    : instr_o = '{MUL_P, 6'o63, 6'o62};
            VER2_PA_S + 2    : instr_o = '{SUB_P, 6'o64, 6'o61};
            VER2_PA_E        : instr_o = '{MUL_P, 6'o65, 6'o64};
            default          : instr_o = '{NOP, 6'o00, 6'o00};   // NOP_A and unused words
        endcase
    end

    // Sequencer never walks past the last routine
    assert property (@(posedge clk) disable iff (!reset_n) addr_i <= VER2_PA_E);

endmodule

// ==== hw/pm_scalar_regs.sv ====
`include "pm_defs.svh"

module pm_scalar_regs (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   start_i,
    input  pm_uop_pkg::pm_cmd_t    cmd_i,
    input  logic                   sca_en_i,
    input  logic                   scalar_wr_i,
    input  pm_uop_pkg::pm_scalar_t scalar_i,
    input  pm_uop_pkg::pm_rnd_t    rnd_i,
    pm_cmd_if.regs                 cmd_if
);
    import pm_uop_pkg::*;

    localparam int WIN_W = `PM_SCALAR_W + `PM_RND_W;

    pm_scalar_t       scalar_q;
    pm_rnd_t          rnd_q;
    logic [WIN_W-1:0] window_q;   // Effective scalar, MSB-aligned
    pm_cmd_t          cmd_q;
    logic             sca_en_q;
    logic             start_ok;
    logic             long_win;

    // Start only from idle and only with a real command
    assign start_ok = start_i && !cmd_if.busy && (cmd_i inside {KEYGEN, SIGN, VER0, VER1, VER2});
    // Random extension only protects keygen and sign
    assign long_win = sca_en_i && (cmd_i inside {KEYGEN, SIGN});

    // ------------------------------------------------------------------
    // Host scalar and digit window
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (scalar_wr_i) begin
            scalar_q <= scalar_i;
            rnd_q    <= rnd_i;
        end
    end

    always_ff @(posedge clk) begin
        if (start_ok) begin
            // Left-align so the first digit always sits at the top bit
            window_q <= long_win ? {rnd_q, scalar_q} : {scalar_q, {`PM_RND_W{1'b0}}};
        end else if (cmd_if.req_digit) begin
            window_q <= window_q << 1;     // Next digit, MSB first
        end
    end

    // Command held until the controller reports busy
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cmd_q    <= IDLE;
            sca_en_q <= 1'b0;
        end else if (start_ok) begin
            cmd_q    <= cmd_i;
            sca_en_q <= sca_en_i;
        end else if (cmd_if.busy) begin
            cmd_q    <= IDLE;
        end
    end

    assign cmd_if.cmd    = cmd_q;
    assign cmd_if.sca_en = sca_en_q;
    assign cmd_if.digit  = window_q[WIN_W-1];

    // Digit requests only come from a running ladder
    assert property (@(posedge clk) disable iff (!reset_n) cmd_if.req_digit |-> cmd_if.busy);

endmodule

// ==== hw/pm_uop_pkg.sv ====
package pm_uop_pkg;

`include "pm_defs.svh"

    // ------------------------------------------------------------------
    // Micro-instruction fields
    // ------------------------------------------------------------------
    typedef logic [3:0]                   pm_opcode_t;     // [3] add_en, [2] mult_en
    typedef logic [`PM_OPR_ADDR_W-1:0]    pm_opr_addr_t;
    typedef logic [`PM_PROG_ADDR_W-1:0]   pm_prog_addr_t;
    typedef logic [`PM_SCALAR_W-1:0]      pm_scalar_t;
    typedef logic [`PM_RND_W-1:0]         pm_rnd_t;

    localparam int OP_ADD_EN_BIT = 3;
    localparam int OP_MUL_EN_BIT = 2;

    localparam pm_opcode_t NOP   = 4'b0000;
    localparam pm_opcode_t STORE = 4'b0001;   // No arithmetic, no stall
    localparam pm_opcode_t ADD_P = 4'b1000;
    localparam pm_opcode_t SUB_P = 4'b1001;
    localparam pm_opcode_t ADD_Q = 4'b1010;   // Mod q variants
    localparam pm_opcode_t SUB_Q = 4'b1011;
    localparam pm_opcode_t MUL_P = 4'b0100;
    localparam pm_opcode_t MUL_Q = 4'b0101;

    localparam logic [2:0] LADDER_BANK = 3'd1;  // R0/R1 pair, swapped by digit

    typedef struct packed {
        pm_opcode_t   opcode;
        pm_opr_addr_t opa_addr;     // Add/sub result side
        pm_opr_addr_t opb_addr;     // Mult result side
    } pm_instr_t;

    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        KEYGEN = 3'd1,
        SIGN   = 3'd2,
        VER0   = 3'd3,
        VER1   = 3'd4,
        VER2   = 3'd5
    } pm_cmd_t;

    // ------------------------------------------------------------------
    // Routine boundaries in the microcode ROM
    // ------------------------------------------------------------------
    localparam pm_prog_addr_t NOP_A        = 7'd0;
    localparam pm_prog_addr_t PM_INIT_G_S  = 7'd1;
    localparam pm_prog_addr_t PM_INIT_G_E  = 7'd3;
    localparam pm_prog_addr_t PM_INIT_PK_S = 7'd4;
    localparam pm_prog_addr_t PM_INIT_PK_E = 7'd6;
    localparam pm_prog_addr_t PM_INIT_S    = 7'd7;
    localparam pm_prog_addr_t PM_INIT_E    = 7'd10;
    localparam pm_prog_addr_t PA_S         = 7'd11;
    localparam pm_prog_addr_t PA_E         = 7'd14;
    localparam pm_prog_addr_t PD_S         = 7'd15;
    localparam pm_prog_addr_t PD_E         = 7'd18;
    localparam pm_prog_addr_t INV_S        = 7'd19;
    localparam pm_prog_addr_t INV_E        = 7'd22;
    localparam pm_prog_addr_t CONV_S       = 7'd23;
    localparam pm_prog_addr_t CONV_E       = 7'd26;
    localparam pm_prog_addr_t SIGN0_S      = 7'd27;
    localparam pm_prog_addr_t SIGN0_E      = 7'd29;
    localparam pm_prog_addr_t INVQ_S       = 7'd30;
    localparam pm_prog_addr_t INVQ_E       = 7'd32;
    localparam pm_prog_addr_t SIGN1_S      = 7'd33;
    localparam pm_prog_addr_t SIGN1_E      = 7'd35;
    localparam pm_prog_addr_t VER0_P0_S    = 7'd36;
    localparam pm_prog_addr_t VER0_P0_E    = 7'd38;
    localparam pm_prog_addr_t VER0_P1_S    = 7'd39;
    localparam pm_prog_addr_t VER0_P1_E    = 7'd41;
    localparam pm_prog_addr_t VER1_ST_S    = 7'd42;
    localparam pm_prog_addr_t VER1_ST_E    = 7'd43;
    localparam pm_prog_addr_t VER2_PA_S    = 7'd44;
    localparam pm_prog_addr_t VER2_PA_E    = 7'd47;

endpackage

// ==== sim/pm_vectors.txt ====
# cmd(1 keygen 2 sign 3 ver0 4 ver1 5 ver2) sca_en scalar rnd gen_rnd steps
# gen_rnd 1 replaces rnd with a seeded random value, steps is the ladder count
1 0 a5c3 00 0 16
1 0 0001 ff 0 16
1 1 8e21 b4 0 24
1 1 3c0f 00 1 24
2 0 1234 00 0 16
2 1 fedc 5a 0 24
2 1 0f0f 00 1 24
4 1 c0de 77 0 16
4 0 ffff 00 1 16
3 0 dead 00 0 0
3 1 beef 11 0 0
5 0 7e81 00 0 16
5 1 4ab9 c6 0 16

// ==== sim/tb_pm_ctrl.sv ====
`include "pm_defs.svh"

module tb_pm_ctrl;

    localparam int         MAX_VEC       = 32;
    localparam int         CYC_PER_VEC   = 4000;
    localparam int         WIN_W         = `PM_SCALAR_W + `PM_RND_W;
    localparam int         BUSY_START_AT = 10;      // Cycle of the ignored extra start
    localparam logic [3:0] OP_NOP        = 4'h0;

    logic                      clk;
    logic                      reset_n;
    logic                      start_i;
    logic [2:0]                cmd_i;
    logic                      sca_en_i;
    logic                      scalar_wr_i;
    logic [`PM_SCALAR_W-1:0]   scalar_i;
    logic [`PM_RND_W-1:0]      rnd_i;
    logic                      busy_o;
    logic [3:0]                opcode_o;
    logic [`PM_OPR_ADDR_W-1:0] opa_addr_o;
    logic [`PM_OPR_ADDR_W-1:0] opb_addr_o;

    // Vector table with one entry per file line
    logic [2:0]              vec_cmd    [MAX_VEC];
    logic                    vec_sca    [MAX_VEC];
    logic [`PM_SCALAR_W-1:0] vec_scalar [MAX_VEC];
    logic [`PM_RND_W-1:0]    vec_rnd    [MAX_VEC];
    logic                    vec_gen    [MAX_VEC];   // Draw rnd from $urandom
    int                      vec_steps  [MAX_VEC];

    int n_vec       = 0;
    int errors      = 0;
    int checks      = 0;
    int cycle_cnt   = 0;
    int cycle_limit = 0;   // Zero until the vectors are loaded

    pm_ctrl_top i_pm_ctrl_top (
        .clk         (clk),
        .reset_n     (reset_n),
        .start_i     (start_i),
        .cmd_i       (cmd_i),
        .sca_en_i    (sca_en_i),
        .scalar_wr_i (scalar_wr_i),
        .scalar_i    (scalar_i),
        .rnd_i       (rnd_i),
        .busy_o      (busy_o),
        .opcode_o    (opcode_o),
        .opa_addr_o  (opa_addr_o),
        .opb_addr_o  (opb_addr_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Watchdog over the whole run
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if ((cycle_limit > 0) && (cycle_cnt >= cycle_limit)) begin
            $display("Timeout after %0d cycles, a command never finished", cycle_cnt);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    // ------------------------------------------------------------------
    // Run one command from scalar load until the stream has drained
    // ------------------------------------------------------------------
    task automatic run_vector(input int idx);
        logic [`PM_RND_W-1:0]       rnd;
        logic [WIN_W-1:0]           window;
        logic [3:0]                 prev_op;
        logic [`PM_OPR_ADDR_W-1:0]  prev_a;
        logic [`PM_OPR_ADDR_W-1:0]  prev_b;
        logic                       fell;
        logic                       done;
        int                         run_len;
        int                         bank1_cnt;
        int                         step;
        int                         n;
        rnd = vec_gen[idx] ? `PM_RND_W'($urandom) : vec_rnd[idx];
        // Effective window read MSB first with random bits only for keygen and sign
        if (vec_sca[idx] && (vec_cmd[idx] inside {3'd1, 3'd2}))
            window = {rnd, vec_scalar[idx]};
        else
            window = {vec_scalar[idx], {`PM_RND_W{1'b0}}};
        @(posedge clk);
        scalar_wr_i <= 1'b1;
        scalar_i    <= vec_scalar[idx];
        rnd_i       <= rnd;
        @(posedge clk);
        scalar_wr_i <= 1'b0;
        start_i     <= 1'b1;
        cmd_i       <= vec_cmd[idx];
        sca_en_i    <= vec_sca[idx];
        @(posedge clk);
        start_i     <= 1'b0;
        @(negedge clk);
        check_value("busy_o", busy_o, 1'b1);     // One cycle after the start
        prev_op   = OP_NOP;
        prev_a    = '0;
        prev_b    = '0;
        run_len   = 0;
        bank1_cnt = 0;
        n         = 0;
        fell      = 1'b0;
        done      = 1'b0;
        while (!done) begin
            @(posedge clk);
            start_i <= (n == BUSY_START_AT);
            if (n == BUSY_START_AT) begin
                cmd_i    <= (vec_cmd[idx] == 3'd1) ? 3'd5 : 3'd1;
                sca_en_i <= !vec_sca[idx];
            end
            @(negedge clk);
            n++;
            if ({opcode_o, opa_addr_o, opb_addr_o} != {prev_op, prev_a, prev_b}) begin
                // Previous word closes with a hold set by its opcode
                if (prev_op[2])
                    check_value("mult hold cycles", run_len, `PM_MULT_DELAY + 2);
                else if (prev_op[3])
                    check_value("add hold cycles", run_len, `PM_ADD_DELAY + 2);
                else if (prev_op != OP_NOP)
                    check_value("store hold cycles", run_len, 1);
                if ((opcode_o != OP_NOP) && (opa_addr_o[5:3] == 3'd1)) begin
                    step = bank1_cnt / `PM_LADDER_UOPS;
                    if (step < WIN_W) begin
                        check_value("opa_addr_o[2]", opa_addr_o[2], window[WIN_W-1-step]);
                        if (opb_addr_o[5:3] == 3'd1)
                            check_value("opb_addr_o[2]", opb_addr_o[2],
                                        window[WIN_W-1-step]);
                    end
                    bank1_cnt++;
                end
                prev_op = opcode_o;
                prev_a  = opa_addr_o;
                prev_b  = opb_addr_o;
                run_len = 1;
            end else begin
                run_len++;
            end
            if (!busy_o)
                fell = 1'b1;
            if (fell && (opcode_o == OP_NOP))
                done = 1'b1;                        // Pipeline drained
        end
        check_value("ladder steps", bank1_cnt / `PM_LADDER_UOPS, vec_steps[idx]);
        check_value("partial ladder step", bank1_cnt % `PM_LADDER_UOPS, 0);
    endtask

    initial begin
        int    fd;
        int    rc;
        int    v_cmd, v_sca, v_scalar, v_rnd, v_gen, v_steps;
        string line;
        reset_n     = 1'b0;
        start_i     = 1'b0;
        cmd_i       = 3'd0;
        sca_en_i    = 1'b0;
        scalar_wr_i = 1'b0;
        scalar_i    = '0;
        rnd_i       = '0;
        rc = $urandom(32'h9419_b12e);
        fd = $fopen("sim/pm_vectors.txt", "r");
        if (fd == 0) begin
            $display("Cannot open sim/pm_vectors.txt, nothing was run");
            $display("RESULT: FAIL");
            $finish;
        end
        while (!$feof(fd) && (n_vec < MAX_VEC)) begin
            line = "";
            rc   = $fgets(line, fd);
            if ((rc > 0) && (line.getc(0) != "#")) begin   // Skip column notes
                rc = $sscanf(line, "%h %h %h %h %h %d",
                             v_cmd, v_sca, v_scalar, v_rnd, v_gen, v_steps);
                if (rc == 6) begin
                    vec_cmd[n_vec]    = v_cmd[2:0];
                    vec_sca[n_vec]    = v_sca[0];
                    vec_scalar[n_vec] = v_scalar[`PM_SCALAR_W-1:0];
                    vec_rnd[n_vec]    = v_rnd[`PM_RND_W-1:0];
                    vec_gen[n_vec]    = v_gen[0];
                    vec_steps[n_vec]  = v_steps;
                    n_vec++;
                end
            end
        end
        $fclose(fd);
        if (n_vec == 0) begin
            $display("No vectors found in sim/pm_vectors.txt");
            $display("RESULT: FAIL");
            $finish;
        end
        cycle_limit = n_vec * CYC_PER_VEC;
        repeat (8) @(posedge clk);
        reset_n <= 1'b1;
        repeat (4) begin                            // Idle stream before any start
            @(negedge clk);
            check_value("busy_o", busy_o, 1'b0);
            check_value("opcode_o", opcode_o, OP_NOP);
        end
        for (int i = 0; i < n_vec; i++)
            run_vector(i);
        $display("%0d vectors, %0d checks, %0d errors", n_vec, checks, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule
